// File: bridge_pkg.sv
// Shared constants, slave address map and types for the AHB to APB bridge
// The slave count is fixed at four and the ranges must not overlap
// Address ranges are inclusive at both ends

`default_nettype none

package bridge_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int NUM_SLAVES = 4;

  // --------------------------------------------------
  // Slave address map
  // --------------------------------------------------
  localparam logic [ADDR_W-1:0] SLAVE_BASE [NUM_SLAVES] = '{
    32'h0000_0000,
    32'h0000_1000,
    32'h0001_0000,
    32'h0002_0000
  };

  localparam logic [ADDR_W-1:0] SLAVE_LAST [NUM_SLAVES] = '{
    32'h0000_0FFF,
    32'h0000_1FFF,
    32'h0001_00FF,
    32'h0002_0FFF
  };

  // AHB transfer types that start a transfer
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // APB master states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2
  } apb_state_e;

  // One-hot slave select, all zero when no range matches
  typedef logic [NUM_SLAVES-1:0] slave_sel_t;

  // Request captured at the AHB address phase
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    slave_sel_t        sel;
  } ahb_req_t;

  // Response of one APB slave
  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: ahb_addr_decode.sv
// AHB address phase qualifier and slave decoder
// Only NONSEQ and SEQ transfers are taken, and only while hready is high
// An address outside every slave range gives an all-zero select

`default_nettype none

module ahb_addr_decode (
  input  wire logic                          hclk2,
  input  wire logic                          hreset_n2,
  input  wire logic                          hsel,
  input  wire logic [1:0]                    htrans,
  input  wire logic [bridge_pkg::ADDR_W-1:0] haddr,
  input  wire logic                          hwrite,
  input  wire logic                          hready,
  output logic                               accept,
  output bridge_pkg::ahb_req_t               req
);

  logic                   valid_trans;
  bridge_pkg::slave_sel_t hit;

  // Transfer type check
  assign valid_trans = hsel &&
                       ((htrans == bridge_pkg::HTRANS_NONSEQ) ||
                        (htrans == bridge_pkg::HTRANS_SEQ));

  // Accept only while the bridge is not stalling
  assign accept = valid_trans && hready;

  // --------------------------------------------------
  // Range compare against the package map
  // --------------------------------------------------
  always_comb begin
    hit = '0;
    for (int i = 0; i < bridge_pkg::NUM_SLAVES; i++) begin
      hit[i] = (haddr >= bridge_pkg::SLAVE_BASE[i]) &&
               (haddr <= bridge_pkg::SLAVE_LAST[i]);
    end
  end

  // Capture the request on the accept edge
  always_ff @(posedge hclk2 or negedge hreset_n2) begin
    if (!hreset_n2) begin
      req <= '0;
    end else if (accept) begin
      req.addr  <= haddr;
      req.write <= hwrite;
      req.sel   <= hit;
    end
  end

  // Overlapping map entries would select two slaves at once
  sel_onehot0: assert property (
    @(posedge hclk2) disable iff (!hreset_n2)
    $onehot0(req.sel)
  ) else $error("more than one slave selected for one address");

endmodule

`default_nettype wire

// File: bridge_ctrl.sv
// AHB data phase tracking and the APB master FSM
// One transfer is in flight at a time, hready is held low until it ends
// A request with no slave selected ends in IDLE without any APB cycle

`default_nettype none

module bridge_ctrl (
  input  wire logic                          hclk2,
  input  wire logic                          hreset_n2,
  input  wire logic                          accept,
  input  wire bridge_pkg::ahb_req_t          req,
  input  wire logic                          ready,
  output logic                               hready,
  output bridge_pkg::slave_sel_t             psel,
  output logic                               penable,
  output logic [bridge_pkg::ADDR_W-1:0]      paddr,
  output logic                               pwrite,
  output logic                               done
);

  bridge_pkg::apb_state_e state;
  logic                   data_phase;
  logic                   map_miss;
  logic                   apb_done;
  logic                   wait_ready;

  // --------------------------------------------------
  // Completion terms
  // --------------------------------------------------

  // Captured address hit no slave range
  assign map_miss = data_phase && (state == bridge_pkg::IDLE) &&
                    (req.sel == '0);

  // Selected slave finished the access
  assign apb_done = (state == bridge_pkg::ACCESS) && ready;

  // Slave inserting wait states
  assign wait_ready = (state == bridge_pkg::ACCESS) && !ready;

  assign done   = map_miss || apb_done;
  assign hready = ~data_phase;

  // AHB data phase runs from accept to done
  always_ff @(posedge hclk2 or negedge hreset_n2) begin
    if (!hreset_n2) begin
      data_phase <= 1'b0;
    end else if (accept) begin
      data_phase <= 1'b1;
    end else if (done) begin
      data_phase <= 1'b0;
    end
  end

  // --------------------------------------------------
  // APB master FSM
  // --------------------------------------------------
  always_ff @(posedge hclk2 or negedge hreset_n2) begin
    if (!hreset_n2) begin
      state   <= bridge_pkg::IDLE;
      psel    <= '0;
      penable <= 1'b0;
      paddr   <= '0;
      pwrite  <= 1'b0;
    end else begin
      case (state)
        bridge_pkg::IDLE: begin
          // Start only once the request register holds a mapped transfer
          if (data_phase && (req.sel != '0)) begin
            state  <= bridge_pkg::SETUP;
            psel   <= req.sel;
            paddr  <= req.addr;
            pwrite <= req.write;
          end
        end
        bridge_pkg::SETUP: begin
          state   <= bridge_pkg::ACCESS;
          penable <= 1'b1;
        end
        bridge_pkg::ACCESS: begin
          // Hold everything steady until pready
          if (ready) begin
            state   <= bridge_pkg::IDLE;
            psel    <= '0;
            penable <= 1'b0;
          end
        end
        default: begin
          state   <= bridge_pkg::IDLE;
          psel    <= '0;
          penable <= 1'b0;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Protocol checks
  // --------------------------------------------------
  penable_with_psel: assert property (
    @(posedge hclk2) disable iff (!hreset_n2)
    penable |-> (psel != '0)
  ) else $error("penable high with no slave selected");

  // Request register must not be reloaded during the wait
  paddr_held_in_wait: assert property (
    @(posedge hclk2) disable iff (!hreset_n2)
    wait_ready |-> (paddr == req.addr)
  ) else $error("paddr left the captured address while waiting for pready");

endmodule

`default_nettype wire

// File: apb_read_mux.sv
// Response mux for the APB slaves
// ready and read data come only from slaves whose psel bit is set
// hrdata is loaded at completion, zero when no slave is selected

`default_nettype none

module apb_read_mux (
  input  wire logic                          hclk2,
  input  wire logic                          hreset_n2,
  input  wire bridge_pkg::slave_sel_t        psel,
  input  wire bridge_pkg::apb_rsp_t          rsp [bridge_pkg::NUM_SLAVES],
  input  wire logic                          done,
  output logic                               ready,
  output logic [bridge_pkg::DATA_W-1:0]      hrdata
);

  bridge_pkg::slave_sel_t          ready_vec;
  logic [bridge_pkg::DATA_W-1:0]   rdata_or;

  // --------------------------------------------------
  // AND-OR mux over the slave responses
  // --------------------------------------------------
  always_comb begin
    ready_vec = '0;
    rdata_or  = '0;
    for (int i = 0; i < bridge_pkg::NUM_SLAVES; i++) begin
      ready_vec[i] = psel[i] & rsp[i].ready;
      if (psel[i]) begin
        rdata_or = rdata_or | rsp[i].rdata;
      end
    end
  end

  assign ready = |ready_vec;

  // Read data register for the AHB side
  always_ff @(posedge hclk2 or negedge hreset_n2) begin
    if (!hreset_n2) begin
      hrdata <= '0;
    end else if (done) begin
      hrdata <= rdata_or;
    end
  end

endmodule

`default_nettype wire

// File: ahb_apb_bridge.sv
// AHB slave to APB master bridge, single clock and single reset
// hwdata must stay valid for the whole stalled data phase
// No error response, unmapped transfers complete with OKAY semantics

`default_nettype none

module ahb_apb_bridge (
  input  wire logic                          hclk2,
  input  wire logic                          hreset_n2,
  // AHB slave side
  input  wire logic                          hsel,
  input  wire logic [1:0]                    htrans,
  input  wire logic [bridge_pkg::ADDR_W-1:0] haddr,
  input  wire logic                          hwrite,
  input  wire logic [bridge_pkg::DATA_W-1:0] hwdata,
  output logic                               hready,
  output logic [bridge_pkg::DATA_W-1:0]      hrdata,
  // APB master side
  output bridge_pkg::slave_sel_t             psel,
  output logic                               penable,
  output logic [bridge_pkg::ADDR_W-1:0]      paddr,
  output logic                               pwrite,
  output logic [bridge_pkg::DATA_W-1:0]      pwdata,
  input  wire bridge_pkg::apb_rsp_t          rsp [bridge_pkg::NUM_SLAVES]
);

  logic                 accept;
  bridge_pkg::ahb_req_t req;
  logic                 ready;
  logic                 done;

  // Write data goes straight to the slaves
  assign pwdata = hwdata;

  ahb_addr_decode u_decode (
    .hclk2     (hclk2),
    .hreset_n2 (hreset_n2),
    .hsel      (hsel),
    .htrans    (htrans),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .hready    (hready),
    .accept    (accept),
    .req       (req)
  );

  bridge_ctrl u_ctrl (
    .hclk2     (hclk2),
    .hreset_n2 (hreset_n2),
    .accept    (accept),
    .req       (req),
    .ready     (ready),
    .hready    (hready),
    .psel      (psel),
    .penable   (penable),
    .paddr     (paddr),
    .pwrite    (pwrite),
    .done      (done)
  );

  apb_read_mux u_read_mux (
    .hclk2     (hclk2),
    .hreset_n2 (hreset_n2),
    .psel      (psel),
    .rsp       (rsp),
    .done      (done),
    .ready     (ready),
    .hrdata    (hrdata)
  );

endmodule

`default_nettype wire

// File: apb_slave_model.sv
// Four APB slave memories of 16 words each, for the bridge testbench
// Every access waits 0 to 3 cycles in ACCESS, drawn from $urandom
// Memories alias through their ranges and are refilled on reset

`default_nettype none

module apb_slave_model (
  input  wire logic                          hclk2,
  input  wire logic                          hreset_n2,
  input  wire bridge_pkg::slave_sel_t        psel,
  input  wire logic                          penable,
  input  wire logic [bridge_pkg::ADDR_W-1:0] paddr,
  input  wire logic                          pwrite,
  input  wire logic [bridge_pkg::DATA_W-1:0] pwdata,
  output bridge_pkg::apb_rsp_t               rsp [bridge_pkg::NUM_SLAVES]
);

  logic [bridge_pkg::DATA_W-1:0] mem [bridge_pkg::NUM_SLAVES][16];
  logic [1:0]                    wait_cnt [bridge_pkg::NUM_SLAVES];
  logic [3:0]                    word_idx;

  assign word_idx = paddr[5:2];

  // Reset contents, built from the full byte address
  function automatic logic [31:0] word_fill(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
  endfunction

  // --------------------------------------------------
  // Wait state counters and write port
  // --------------------------------------------------
  always_ff @(posedge hclk2 or negedge hreset_n2) begin
    if (!hreset_n2) begin
      for (int s = 0; s < bridge_pkg::NUM_SLAVES; s++) begin
        wait_cnt[s] <= 2'd0;
        for (int w = 0; w < 16; w++) begin
          mem[s][w] <= word_fill(bridge_pkg::SLAVE_BASE[s] + 32'(w * 4));
        end
      end
    end else begin
      for (int s = 0; s < bridge_pkg::NUM_SLAVES; s++) begin
        if (psel[s] && !penable) begin
          // New wait count in SETUP
          wait_cnt[s] <= 2'($urandom % 4);
        end else if (psel[s] && penable) begin
          if (wait_cnt[s] != 2'd0) begin
            wait_cnt[s] <= wait_cnt[s] - 2'd1;
          end else if (pwrite) begin
            mem[s][word_idx] <= pwdata;
          end
        end
      end
    end
  end

  // Unselected slaves still drive ready and data, the bridge must mask them
  always_comb begin
    for (int s = 0; s < bridge_pkg::NUM_SLAVES; s++) begin
      rsp[s].ready = (wait_cnt[s] == 2'd0);
      rsp[s].rdata = mem[s][word_idx];
    end
  end

endmodule

`default_nettype wire

// File: tb_ahb_apb_bridge.sv
// Testbench for the AHB to APB bridge with four APB slave models
// 300 random transfers from a fixed seed, checked against a shadow memory
// Shadow memory aliases by address bits 5:2, like the slave model

`default_nettype none

module tb_ahb_apb_bridge;

  localparam int NUM_TRANSFERS  = 300;
  localparam int TIMEOUT_CYCLES = 4000;

  logic                          hclk2;
  logic                          hreset_n2;
  logic                          hsel;
  logic [1:0]                    htrans;
  logic [bridge_pkg::ADDR_W-1:0] haddr;
  logic                          hwrite;
  logic [bridge_pkg::DATA_W-1:0] hwdata;
  logic                          hready;
  logic [bridge_pkg::DATA_W-1:0] hrdata;
  bridge_pkg::slave_sel_t        psel;
  logic                          penable;
  logic [bridge_pkg::ADDR_W-1:0] paddr;
  logic                          pwrite;
  logic [bridge_pkg::DATA_W-1:0] pwdata;
  bridge_pkg::apb_rsp_t          rsp [bridge_pkg::NUM_SLAVES];

  logic [bridge_pkg::DATA_W-1:0] shadow [bridge_pkg::NUM_SLAVES][16];
  int                            error_count;
  int                            check_count;
  int                            cycle_count;

  ahb_apb_bridge dut_i (
    .hclk2(hclk2), .hreset_n2(hreset_n2), .hsel(hsel), .htrans(htrans),
    .haddr(haddr), .hwrite(hwrite), .hwdata(hwdata), .hready(hready),
    .hrdata(hrdata), .psel(psel), .penable(penable), .paddr(paddr),
    .pwrite(pwrite), .pwdata(pwdata), .rsp(rsp)
  );

  apb_slave_model slaves_i (
    .hclk2(hclk2), .hreset_n2(hreset_n2), .psel(psel), .penable(penable),
    .paddr(paddr), .pwrite(pwrite), .pwdata(pwdata), .rsp(rsp)
  );

  initial begin
    hclk2 = 1'b0;
    forever #10 hclk2 = ~hclk2;
  end

  // --------------------------------------------------
  // Reference helpers
  // --------------------------------------------------
  function automatic bridge_pkg::slave_sel_t expected_sel(input logic [31:0] addr);
    bridge_pkg::slave_sel_t sel;
    sel = '0;
    for (int i = 0; i < bridge_pkg::NUM_SLAVES; i++) begin
      if (addr >= bridge_pkg::SLAVE_BASE[i] && addr <= bridge_pkg::SLAVE_LAST[i]) begin
        sel[i] = 1'b1;
      end
    end
    return sel;
  endfunction

  function automatic int slave_index(input bridge_pkg::slave_sel_t sel);
    int idx;
    idx = 0;
    for (int i = 0; i < bridge_pkg::NUM_SLAVES; i++) begin
      if (sel[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // Same reset pattern the slave memories start from
  function automatic logic [31:0] initial_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    check_count++;
    assert (ok === 1'b1) else begin
      error_count++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  // --------------------------------------------------
  // One AHB transfer, watched cycle by cycle at negedge
  // --------------------------------------------------
  task automatic run_transfer(input logic [31:0] addr, input logic write,
                              input logic [31:0] wdata, input logic [1:0] trans);
    bridge_pkg::slave_sel_t sel;
    int                     idx;
    int                     low_cycles;
    logic                   finished;
    logic                   was_ready;
    sel        = expected_sel(addr);
    idx        = slave_index(sel);
    low_cycles = 0;
    finished   = 1'b0;
    was_ready  = 1'b0;
    @(posedge hclk2);
    hsel   <= 1'b1;
    htrans <= trans;
    haddr  <= addr;
    hwrite <= write;
    hwdata <= wdata;
    @(negedge hclk2);
    check_true(hready, "hready low when a transfer was offered");
    @(posedge hclk2);
    // Random offer on the bus while stalled, hwdata kept
    hsel   <= 1'($urandom % 2);
    htrans <= 2'($urandom % 4);
    haddr  <= $urandom;
    hwrite <= 1'($urandom % 2);
    while (!finished) begin
      @(negedge hclk2);
      if (hready) begin
        finished = 1'b1;
      end else begin
        low_cycles++;
        check_true(!was_ready, "transfer still stalled after pready was high");
        if (low_cycles == 1 || sel == '0) begin
          check_value("psel", 32'(psel), 32'd0);
          check_value("penable", 32'(penable), 32'd0);
        end else begin
          check_value("psel", 32'(psel), 32'(sel));
          check_value("paddr", paddr, addr);
          check_value("pwrite", 32'(pwrite), 32'(write));
          check_value("pwdata", pwdata, wdata);
          check_value("penable", 32'(penable), 32'(low_cycles >= 3));
        end
        // Pready seen in ACCESS must end the stall at the next edge
        if (low_cycles >= 3) begin
          for (int i = 0; i < bridge_pkg::NUM_SLAVES; i++) begin
            if (sel[i] && rsp[i].ready) begin
              was_ready = 1'b1;
            end
          end
        end
        if (low_cycles == 1) begin
          // Offer seen at one stalled edge only, then back to idle
          @(posedge hclk2);
          hsel   <= 1'b0;
          htrans <= 2'b00;
        end
      end
    end
    if (sel == '0) begin
      check_value("hready low cycles", 32'(low_cycles), 32'd1);
    end else begin
      check_true(low_cycles >= 3, "mapped transfer stalled fewer than three cycles");
      check_true(was_ready, "transfer completed without pready from its slave");
    end
    check_value("psel", 32'(psel), 32'd0);
    check_value("penable", 32'(penable), 32'd0);
    if (!write) begin
      check_value("hrdata", hrdata, (sel == '0) ? 32'd0 : shadow[idx][addr[5:2]]);
    end else if (sel != '0) begin
      shadow[idx][addr[5:2]] = wdata;
    end
  endtask

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge hclk2);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    $display("CHECKS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Main stimulus
  // --------------------------------------------------
  initial begin
    int          target;
    int          gap;
    logic [31:0] span;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        write;
    logic [1:0]  trans;
    void'($urandom(96138));
    error_count = 0;
    check_count = 0;
    hreset_n2   = 1'b0;
    hsel        = 1'b0;
    htrans      = 2'b00;
    haddr       = '0;
    hwrite      = 1'b0;
    hwdata      = '0;
    for (int s = 0; s < bridge_pkg::NUM_SLAVES; s++) begin
      for (int w = 0; w < 16; w++) begin
        shadow[s][w] = initial_word(bridge_pkg::SLAVE_BASE[s] + 32'(w * 4));
      end
    end
    repeat (4) @(posedge hclk2);
    hreset_n2 <= 1'b1;
    @(negedge hclk2);
    check_true(hready, "hready not high after reset");
    check_value("psel", 32'(psel), 32'd0);
    check_value("penable", 32'(penable), 32'd0);
    check_value("pwrite", 32'(pwrite), 32'd0);

    for (int n = 0; n < NUM_TRANSFERS; n++) begin
      target = int'($urandom % 5);
      if (target < bridge_pkg::NUM_SLAVES) begin
        span = bridge_pkg::SLAVE_LAST[target] - bridge_pkg::SLAVE_BASE[target] + 32'd1;
        addr = bridge_pkg::SLAVE_BASE[target] + (($urandom % span) & 32'hFFFF_FFFC);
      end else begin
        // Holes between and above the slave ranges
        case ($urandom % 3)
          0:       addr = 32'h0001_0100 + (($urandom % 32'h100) & 32'hFFFF_FFFC);
          1:       addr = 32'h0000_2000 + (($urandom % 32'h1000) & 32'hFFFF_FFFC);
          default: addr = ($urandom | 32'h8000_0000) & 32'hFFFF_FFFC;
        endcase
      end
      write = 1'($urandom % 2);
      wdata = $urandom;
      trans = ($urandom % 2 == 0) ? bridge_pkg::HTRANS_NONSEQ : bridge_pkg::HTRANS_SEQ;
      gap   = int'($urandom % 3);
      repeat (gap) @(posedge hclk2);
      run_transfer(addr, write, wdata, trans);
    end

    repeat (2) @(posedge hclk2);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
bridge_pkg.sv
ahb_addr_decode.sv
bridge_ctrl.sv
apb_read_mux.sv
ahb_apb_bridge.sv
apb_slave_model.sv
tb_ahb_apb_bridge.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tb_ahb_apb_bridge
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
